/* hw/id_pkg.sv */
package id_pkg;

    parameter int XLEN     = 32;
    parameter int REG_AW   = 5;
    parameter int NUM_REGS = 32;

    // bl links into r1
    parameter logic [REG_AW-1:0] RA_REG = 5'd1;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JIRL,
        BR_B,
        BR_BL
    } branch_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LD_B,
        MEM_LD_H,
        MEM_LD_W,
        MEM_LD_BU,
        MEM_LD_HU,
        MEM_ST_B,
        MEM_ST_H,
        MEM_ST_W
    } mem_op_e;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
    } fetch_bundle_t;

    // one result port of a later stage
    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
    } bypass_t;

    typedef struct packed {
        logic    is_load;
        bypass_t port;
    } ex_bypass_t;

    typedef struct packed {
        alu_op_e           alu_op;
        branch_e           branch;
        mem_op_e           mem_op;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   br_offs;
        logic              src1_is_pc;
        logic              src2_is_imm;
        logic              rf_we;
        logic [REG_AW-1:0] dest;
        logic [REG_AW-1:0] rj;
        logic [REG_AW-1:0] rkd;
        logic              need_rj;
        logic              need_rkd;
    } decode_t;

    typedef struct packed {
        alu_op_e           alu_op;
        logic [XLEN-1:0]   alu_src1;
        logic [XLEN-1:0]   alu_src2;
        logic              rf_we;
        logic [REG_AW-1:0] dest;
        logic [XLEN-1:0]   pc;
        mem_op_e           mem_op;
        logic [XLEN-1:0]   store_data;
    } ex_bundle_t;

endpackage

/* hw/inst_decoder.sv */
module inst_decoder (
    input  logic [id_pkg::XLEN-1:0] i_inst,
    output id_pkg::decode_t         o_dec
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;

    assign op_31_26 = i_inst[31:26];
    assign op_25_22 = i_inst[25:22];
    assign op_21_20 = i_inst[21:20];
    assign op_19_15 = i_inst[19:15];
    assign rd       = i_inst[4:0];
    assign rj       = i_inst[9:5];
    assign rk       = i_inst[14:10];
    assign i12      = i_inst[21:10];
    assign i20      = i_inst[24:5];
    assign i16      = i_inst[25:10];
    assign i26      = {i_inst[9:0], i_inst[25:10]};

    // opcode groups
    wire grp_3r  = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    wire grp_shi = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);
    wire grp_2ri = (op_31_26 == 6'h00);
    wire grp_mem = (op_31_26 == 6'h0a);

    wire inst_add_w  = grp_3r && (op_19_15 == 5'h00);
    wire inst_sub_w  = grp_3r && (op_19_15 == 5'h02);
    wire inst_slt    = grp_3r && (op_19_15 == 5'h04);
    wire inst_sltu   = grp_3r && (op_19_15 == 5'h05);
    wire inst_nor    = grp_3r && (op_19_15 == 5'h08);
    wire inst_and    = grp_3r && (op_19_15 == 5'h09);
    wire inst_or     = grp_3r && (op_19_15 == 5'h0a);
    wire inst_xor    = grp_3r && (op_19_15 == 5'h0b);
    wire inst_sll_w  = grp_3r && (op_19_15 == 5'h0e);
    wire inst_srl_w  = grp_3r && (op_19_15 == 5'h0f);
    wire inst_sra_w  = grp_3r && (op_19_15 == 5'h10);

    wire inst_slli_w = grp_shi && (op_19_15 == 5'h01);
    wire inst_srli_w = grp_shi && (op_19_15 == 5'h09);
    wire inst_srai_w = grp_shi && (op_19_15 == 5'h11);

    wire inst_slti   = grp_2ri && (op_25_22 == 4'h8);
    wire inst_sltui  = grp_2ri && (op_25_22 == 4'h9);
    wire inst_addi_w = grp_2ri && (op_25_22 == 4'ha);
    wire inst_andi   = grp_2ri && (op_25_22 == 4'hd);
    wire inst_ori    = grp_2ri && (op_25_22 == 4'he);
    wire inst_xori   = grp_2ri && (op_25_22 == 4'hf);

    wire inst_ld_b   = grp_mem && (op_25_22 == 4'h0);
    wire inst_ld_h   = grp_mem && (op_25_22 == 4'h1);
    wire inst_ld_w   = grp_mem && (op_25_22 == 4'h2);
    wire inst_st_b   = grp_mem && (op_25_22 == 4'h4);
    wire inst_st_h   = grp_mem && (op_25_22 == 4'h5);
    wire inst_st_w   = grp_mem && (op_25_22 == 4'h6);
    wire inst_ld_bu  = grp_mem && (op_25_22 == 4'h8);
    wire inst_ld_hu  = grp_mem && (op_25_22 == 4'h9);

    wire inst_jirl   = (op_31_26 == 6'h13);
    wire inst_b      = (op_31_26 == 6'h14);
    wire inst_bl     = (op_31_26 == 6'h15);
    wire inst_beq    = (op_31_26 == 6'h16);
    wire inst_bne    = (op_31_26 == 6'h17);
    wire inst_blt    = (op_31_26 == 6'h18);
    wire inst_bge    = (op_31_26 == 6'h19);
    wire inst_bltu   = (op_31_26 == 6'h1a);
    wire inst_bgeu   = (op_31_26 == 6'h1b);

    wire inst_lu12i  = (op_31_26 == 6'h05) && !i_inst[25];
    wire inst_pcadd  = (op_31_26 == 6'h07) && !i_inst[25];

    wire alu_3r    = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and |
                     inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
    wire shift_imm = inst_slli_w | inst_srli_w | inst_srai_w;
    wire logic_imm = inst_andi | inst_ori | inst_xori;
    wire arith_imm = inst_addi_w | inst_slti | inst_sltui;
    wire is_load   = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    wire is_store  = inst_st_b | inst_st_h | inst_st_w;
    wire cond_br   = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    wire link_4    = inst_jirl | inst_bl;
    wire upper_imm = inst_lu12i | inst_pcadd;

    always_comb begin
        o_dec = '0;

        if (inst_sub_w)                    o_dec.alu_op = id_pkg::ALU_SUB;
        else if (inst_slt || inst_slti)    o_dec.alu_op = id_pkg::ALU_SLT;
        else if (inst_sltu || inst_sltui)  o_dec.alu_op = id_pkg::ALU_SLTU;
        else if (inst_and || inst_andi)    o_dec.alu_op = id_pkg::ALU_AND;
        else if (inst_nor)                 o_dec.alu_op = id_pkg::ALU_NOR;
        else if (inst_or || inst_ori)      o_dec.alu_op = id_pkg::ALU_OR;
        else if (inst_xor || inst_xori)    o_dec.alu_op = id_pkg::ALU_XOR;
        else if (inst_sll_w || inst_slli_w) o_dec.alu_op = id_pkg::ALU_SLL;
        else if (inst_srl_w || inst_srli_w) o_dec.alu_op = id_pkg::ALU_SRL;
        else if (inst_sra_w || inst_srai_w) o_dec.alu_op = id_pkg::ALU_SRA;
        else if (inst_lu12i)               o_dec.alu_op = id_pkg::ALU_LUI;
        else                               o_dec.alu_op = id_pkg::ALU_ADD;

        if (inst_beq)       o_dec.branch = id_pkg::BR_BEQ;
        else if (inst_bne)  o_dec.branch = id_pkg::BR_BNE;
        else if (inst_blt)  o_dec.branch = id_pkg::BR_BLT;
        else if (inst_bge)  o_dec.branch = id_pkg::BR_BGE;
        else if (inst_bltu) o_dec.branch = id_pkg::BR_BLTU;
        else if (inst_bgeu) o_dec.branch = id_pkg::BR_BGEU;
        else if (inst_jirl) o_dec.branch = id_pkg::BR_JIRL;
        else if (inst_b)    o_dec.branch = id_pkg::BR_B;
        else if (inst_bl)   o_dec.branch = id_pkg::BR_BL;
        else                o_dec.branch = id_pkg::BR_NONE;

        if (inst_ld_b)       o_dec.mem_op = id_pkg::MEM_LD_B;
        else if (inst_ld_h)  o_dec.mem_op = id_pkg::MEM_LD_H;
        else if (inst_ld_w)  o_dec.mem_op = id_pkg::MEM_LD_W;
        else if (inst_ld_bu) o_dec.mem_op = id_pkg::MEM_LD_BU;
        else if (inst_ld_hu) o_dec.mem_op = id_pkg::MEM_LD_HU;
        else if (inst_st_b)  o_dec.mem_op = id_pkg::MEM_ST_B;
        else if (inst_st_h)  o_dec.mem_op = id_pkg::MEM_ST_H;
        else if (inst_st_w)  o_dec.mem_op = id_pkg::MEM_ST_W;
        else                 o_dec.mem_op = id_pkg::MEM_NONE;

        // link value is pc + 4
        if (link_4)
            o_dec.imm = 32'd4;
        else if (upper_imm)
            o_dec.imm = {i20, 12'b0};
        else if (shift_imm || arith_imm || is_load || is_store)
            o_dec.imm = {{20{i12[11]}}, i12};
        else
            o_dec.imm = {20'b0, i12};

        if (inst_b || inst_bl)
            o_dec.br_offs = {{4{i26[25]}}, i26, 2'b0};
        else
            o_dec.br_offs = {{14{i16[15]}}, i16, 2'b0};

        o_dec.src1_is_pc  = link_4 | inst_pcadd;
        o_dec.src2_is_imm = shift_imm | logic_imm | arith_imm | is_load | is_store |
                            link_4 | upper_imm;
        o_dec.rf_we       = alu_3r | shift_imm | logic_imm | arith_imm | is_load |
                            link_4 | upper_imm;
        o_dec.dest        = inst_bl ? id_pkg::RA_REG : rd;
        o_dec.rj          = rj;
        o_dec.rkd         = (cond_br || is_store) ? rd : rk;
        o_dec.need_rj     = alu_3r | shift_imm | logic_imm | arith_imm | is_load | is_store |
                            cond_br | inst_jirl;
        o_dec.need_rkd    = alu_3r | is_store | cond_br;
    end

endmodule

/* hw/operand_fetch.sv */
module operand_fetch (
    input  logic                     clk,
    input  logic                     resetn,
    input  id_pkg::decode_t          i_dec,
    input  logic                     i_valid,
    input  id_pkg::ex_bypass_t       i_ex_bypass,
    input  id_pkg::bypass_t          i_mem_bypass,
    input  id_pkg::bypass_t          i_wb_bypass,
    output logic [id_pkg::XLEN-1:0]  o_rj_value,
    output logic [id_pkg::XLEN-1:0]  o_rkd_value,
    output logic                     o_stall
);

    logic [id_pkg::XLEN-1:0] rf [id_pkg::NUM_REGS];
    logic                    ex_hit_rj;
    logic                    ex_hit_rkd;

    // nonzero source written by this port
    function automatic logic port_hit(
        input logic [id_pkg::REG_AW-1:0] addr,
        input id_pkg::bypass_t           port
    );
        port_hit = port.we && (addr != '0) && (addr == port.waddr);
    endfunction

    // youngest producer first: ex, then mem, then wb, then the file
    function automatic logic [id_pkg::XLEN-1:0] read_src(
        input logic [id_pkg::REG_AW-1:0] addr
    );
        logic [id_pkg::XLEN-1:0] file_data;
        file_data = (addr == '0) ? '0 : rf[addr];
        if (port_hit(addr, i_ex_bypass.port))
            read_src = i_ex_bypass.port.wdata;
        else if (port_hit(addr, i_mem_bypass))
            read_src = i_mem_bypass.wdata;
        else if (port_hit(addr, i_wb_bypass))
            read_src = i_wb_bypass.wdata;
        else
            read_src = file_data;
    endfunction

    always_ff @(posedge clk) begin
        if (resetn && i_wb_bypass.we && (i_wb_bypass.waddr != '0)) begin
            rf[i_wb_bypass.waddr] <= i_wb_bypass.wdata;
        end
    end

    always_comb begin
        o_rj_value  = read_src(i_dec.rj);
        o_rkd_value = read_src(i_dec.rkd);
    end

    // load data is not ready until mem, so wait a cycle
    assign ex_hit_rj  = i_dec.need_rj && port_hit(i_dec.rj, i_ex_bypass.port);
    assign ex_hit_rkd = i_dec.need_rkd && port_hit(i_dec.rkd, i_ex_bypass.port);
    assign o_stall    = i_valid && i_ex_bypass.is_load && (ex_hit_rj || ex_hit_rkd);

endmodule

/* hw/issue_control.sv */
module issue_control (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     i_if_valid,
    input  id_pkg::fetch_bundle_t    i_if_bundle,
    input  logic                     i_ex_allowin,
    input  id_pkg::decode_t          i_dec,
    input  logic [id_pkg::XLEN-1:0]  i_rj_value,
    input  logic [id_pkg::XLEN-1:0]  i_rkd_value,
    input  logic                     i_stall,
    output logic [id_pkg::XLEN-1:0]  o_inst,
    output logic                     o_valid,
    output logic                     o_id_allowin,
    output logic                     o_br_taken,
    output logic [id_pkg::XLEN-1:0]  o_br_target,
    output logic                     o_ex_valid,
    output id_pkg::ex_bundle_t       o_ex_bundle
);

    id_pkg::fetch_bundle_t stage_q;
    logic                  valid_q;
    logic                  ready_go;
    logic                  br_cond;
    logic [id_pkg::XLEN-1:0] br_base;

    assign ready_go     = !i_stall;
    assign o_id_allowin = !valid_q || (ready_go && i_ex_allowin);
    assign o_ex_valid   = valid_q && ready_go;
    assign o_valid      = valid_q;
    assign o_inst       = stage_q.inst;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (o_br_taken) begin
            // squash whatever fetch offers behind a taken branch
            valid_q <= 1'b0;
        end else if (o_id_allowin) begin
            valid_q <= i_if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_if_valid && o_id_allowin) begin
            stage_q <= i_if_bundle;
        end
    end

    always_comb begin
        unique case (i_dec.branch)
            id_pkg::BR_BEQ:  br_cond = (i_rj_value == i_rkd_value);
            id_pkg::BR_BNE:  br_cond = (i_rj_value != i_rkd_value);
            id_pkg::BR_BLT:  br_cond = ($signed(i_rj_value) < $signed(i_rkd_value));
            id_pkg::BR_BGE:  br_cond = ($signed(i_rj_value) >= $signed(i_rkd_value));
            id_pkg::BR_BLTU: br_cond = (i_rj_value < i_rkd_value);
            id_pkg::BR_BGEU: br_cond = (i_rj_value >= i_rkd_value);
            id_pkg::BR_JIRL,
            id_pkg::BR_B,
            id_pkg::BR_BL:   br_cond = 1'b1;
            default:         br_cond = 1'b0;
        endcase
    end

    // redirect only once execute takes the instruction
    assign o_br_taken  = br_cond && o_ex_valid && i_ex_allowin;
    assign br_base     = (i_dec.branch == id_pkg::BR_JIRL) ? i_rj_value : stage_q.pc;
    assign o_br_target = br_base + i_dec.br_offs;

    always_comb begin
        o_ex_bundle            = '0;
        o_ex_bundle.alu_op     = i_dec.alu_op;
        o_ex_bundle.alu_src1   = i_dec.src1_is_pc ? stage_q.pc : i_rj_value;
        o_ex_bundle.alu_src2   = i_dec.src2_is_imm ? i_dec.imm : i_rkd_value;
        o_ex_bundle.rf_we      = i_dec.rf_we;
        o_ex_bundle.dest       = i_dec.dest;
        o_ex_bundle.pc         = stage_q.pc;
        o_ex_bundle.mem_op     = i_dec.mem_op;
        o_ex_bundle.store_data = i_rkd_value;
    end

endmodule

/* hw/id_stage.sv */
module id_stage (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     i_if_valid,
    input  id_pkg::fetch_bundle_t    i_if_bundle,
    output logic                     o_id_allowin,
    output logic                     o_br_taken,
    output logic [id_pkg::XLEN-1:0]  o_br_target,
    output logic                     o_ex_valid,
    output id_pkg::ex_bundle_t       o_ex_bundle,
    input  logic                     i_ex_allowin,
    input  id_pkg::ex_bypass_t       i_ex_bypass,
    input  id_pkg::bypass_t          i_mem_bypass,
    input  id_pkg::bypass_t          i_wb_bypass
);

    logic [id_pkg::XLEN-1:0] inst;
    logic                    stage_valid;
    id_pkg::decode_t         dec;
    logic [id_pkg::XLEN-1:0] rj_value;
    logic [id_pkg::XLEN-1:0] rkd_value;
    logic                    stall;

    issue_control u_issue_control (
        .clk          (clk),
        .resetn       (resetn),
        .i_if_valid   (i_if_valid),
        .i_if_bundle  (i_if_bundle),
        .i_ex_allowin (i_ex_allowin),
        .i_dec        (dec),
        .i_rj_value   (rj_value),
        .i_rkd_value  (rkd_value),
        .i_stall      (stall),
        .o_inst       (inst),
        .o_valid      (stage_valid),
        .o_id_allowin (o_id_allowin),
        .o_br_taken   (o_br_taken),
        .o_br_target  (o_br_target),
        .o_ex_valid   (o_ex_valid),
        .o_ex_bundle  (o_ex_bundle)
    );

    inst_decoder u_inst_decoder (
        .i_inst (inst),
        .o_dec  (dec)
    );

    operand_fetch u_operand_fetch (
        .clk          (clk),
        .resetn       (resetn),
        .i_dec        (dec),
        .i_valid      (stage_valid),
        .i_ex_bypass  (i_ex_bypass),
        .i_mem_bypass (i_mem_bypass),
        .i_wb_bypass  (i_wb_bypass),
        .o_rj_value   (rj_value),
        .o_rkd_value  (rkd_value),
        .o_stall      (stall)
    );

endmodule

/* test/id_stage_properties.sv */
module id_stage_properties (
    input logic               clk,
    input logic               resetn,
    input logic               o_ex_valid,
    input logic               o_br_taken,
    input logic               i_ex_allowin,
    input id_pkg::ex_bundle_t o_ex_bundle
);

    logic fail_seen = 1'b0;

    // stage comes out of reset empty
    reset_empties: assert property (@(posedge clk) !resetn |=> !o_ex_valid)
        else begin
            $error("o_ex_valid high after reset");
            fail_seen = 1'b1;
        end

    // a taken branch empties the stage behind it
    taken_squashes: assert property (
        @(posedge clk) disable iff (!resetn) o_br_taken |=> !o_ex_valid
    ) else begin
        $error("o_ex_valid high after a taken branch");
        fail_seen = 1'b1;
    end

    // back-pressure keeps the bundle steady
    bundle_holds: assert property (
        @(posedge clk) disable iff (!resetn)
        (o_ex_valid && !i_ex_allowin) |=> $stable(o_ex_bundle)
    ) else begin
        $error("o_ex_bundle changed under back-pressure");
        fail_seen = 1'b1;
    end

endmodule

/* test/id_stage_tb.sv */
module id_stage_tb;

    typedef struct packed {
        logic [31:0]     inst;
        id_pkg::alu_op_e alu;
        id_pkg::mem_op_e mem;
        id_pkg::branch_e brk;
        logic            we;
        logic [4:0]      dest;
        logic [4:0]      rkd;
        logic            use_pc;
        logic            use_imm;
        logic [31:0]     imm;
        logic [31:0]     offs;
        logic [2:0]      mode;
    } row_t;

    logic                  clk = 1'b0;
    logic                  resetn;
    logic                  if_valid;
    id_pkg::fetch_bundle_t if_bundle;
    logic                  ex_allowin;
    id_pkg::ex_bypass_t    ex_bp;
    id_pkg::bypass_t       mem_bp;
    id_pkg::bypass_t       wb_bp;
    logic                  id_allowin;
    logic                  br_taken;
    logic [31:0]           br_target;
    logic                  ex_valid;
    id_pkg::ex_bundle_t    ex_bundle;
    logic [31:0]           shadow [32];
    row_t                  rows [$];

    always #4 clk = ~clk;

    id_stage uut (
        .clk(clk), .resetn(resetn), .i_if_valid(if_valid), .i_if_bundle(if_bundle),
        .o_id_allowin(id_allowin), .o_br_taken(br_taken), .o_br_target(br_target),
        .o_ex_valid(ex_valid), .o_ex_bundle(ex_bundle), .i_ex_allowin(ex_allowin),
        .i_ex_bypass(ex_bp), .i_mem_bypass(mem_bp), .i_wb_bypass(wb_bp)
    );

    bind id_stage id_stage_properties u_props (
        .clk(clk), .resetn(resetn), .o_ex_valid(o_ex_valid), .o_br_taken(o_br_taken),
        .i_ex_allowin(i_ex_allowin), .o_ex_bundle(o_ex_bundle)
    );

    always @(posedge clk) begin
        if (uut.u_props.fail_seen === 1'b1) begin
            $display("a bound assertion failed");
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("error: %s got %h expected %h", name, act, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out waiting for %s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    endtask

    // youngest bypass wins and r0 is always zero
    function automatic logic [31:0] operand_value(input logic [4:0] a);
        if (a == 5'd0) return 32'd0;
        if (ex_bp.port.we && ex_bp.port.waddr == a) return ex_bp.port.wdata;
        if (mem_bp.we && mem_bp.waddr == a) return mem_bp.wdata;
        if (wb_bp.we && wb_bp.waddr == a) return wb_bp.wdata;
        return shadow[a];
    endfunction

    function automatic logic branch_taken(input id_pkg::branch_e k, input logic [31:0] a,
                                          input logic [31:0] b);
        case (k)
            id_pkg::BR_BEQ:  return a == b;
            id_pkg::BR_BNE:  return a != b;
            id_pkg::BR_BLT:  return $signed(a) < $signed(b);
            id_pkg::BR_BGE:  return $signed(a) >= $signed(b);
            id_pkg::BR_BLTU: return a < b;
            id_pkg::BR_BGEU: return a >= b;
            id_pkg::BR_NONE: return 1'b0;
            default:         return 1'b1;
        endcase
    endfunction

    task automatic add_row(input logic [31:0] inst, input id_pkg::alu_op_e alu,
                           input id_pkg::mem_op_e mem, input id_pkg::branch_e brk,
                           input logic we, input logic [4:0] dest, input logic [4:0] rkd,
                           input logic use_pc, input logic use_imm, input logic [31:0] imm,
                           input logic [31:0] offs, input logic [2:0] mode);
        rows.push_back({inst, alu, mem, brk, we, dest, rkd, use_pc, use_imm, imm, offs, mode});
    endtask

    task automatic r3(input logic [4:0] op, input id_pkg::alu_op_e alu, input logic [4:0] rd,
                      input logic [4:0] rj, input logic [4:0] rk, input logic [2:0] mode);
        add_row({6'h00, 4'h0, 2'h1, op, rk, rj, rd}, alu, id_pkg::MEM_NONE, id_pkg::BR_NONE,
                1'b1, rd, rk, 1'b0, 1'b0, 32'd0, 32'd0, mode);
    endtask

    task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
        if (a != 5'd0) begin
            @(posedge clk);
            wb_bp <= {1'b1, a, d};
            @(posedge clk);
            wb_bp <= '0;
            shadow[a] = d;
        end
    endtask

    task automatic fetch(input logic [31:0] inst, input logic [31:0] pc);
        int n;
        n = 0;
        @(posedge clk);
        if_valid  <= 1'b1;
        if_bundle <= {inst, pc};
        @(negedge clk);
        while (!id_allowin) begin
            n++;
            if (n > 20) timeout_fail("o_id_allowin");
            @(negedge clk);
        end
        @(posedge clk);
        if_valid <= 1'b0;
    endtask

    task automatic wait_ex_valid();
        int n;
        n = 0;
        @(negedge clk);
        while (!ex_valid) begin
            n++;
            if (n > 20) timeout_fail("o_ex_valid");
            @(negedge clk);
        end
    endtask

    task automatic check_outputs(input row_t r, input logic [31:0] pc);
        logic [31:0] a;
        logic [31:0] b;
        a = operand_value(r.inst[9:5]);
        b = operand_value(r.rkd);
        check("alu_op", 32'(ex_bundle.alu_op), 32'(r.alu));
        check("alu_src1", ex_bundle.alu_src1, r.use_pc ? pc : a);
        check("alu_src2", ex_bundle.alu_src2, r.use_imm ? r.imm : b);
        check("rf_we", 32'(ex_bundle.rf_we), 32'(r.we));
        check("dest", 32'(ex_bundle.dest), 32'(r.dest));
        check("pc", ex_bundle.pc, pc);
        check("mem_op", 32'(ex_bundle.mem_op), 32'(r.mem));
        check("store_data", ex_bundle.store_data, b);
        check("o_br_taken", 32'(br_taken), 32'(branch_taken(r.brk, a, b)));
        if (r.brk != id_pkg::BR_NONE)
            check("o_br_target", br_target, (r.brk == id_pkg::BR_JIRL ? a : pc) + r.offs);
    endtask

    task automatic run_row(input row_t r, input logic [31:0] pc);
        logic [4:0]  rj;
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] d2;
        id_pkg::ex_bundle_t held;
        rj = r.inst[9:5];
        write_reg(rj, $urandom);
        write_reg(r.rkd, $urandom);
        d0 = $urandom;
        d1 = $urandom;
        d2 = $urandom;
        fetch(r.inst, pc);
        if (r.mode == 3'd1) ex_bp <= {1'b0, 1'b1, rj, d0};
        if (r.mode >= 3'd1 && r.mode <= 3'd2) mem_bp <= {1'b1, rj, d1};
        if (r.mode >= 3'd1 && r.mode <= 3'd3) wb_bp <= {1'b1, rj, d2};
        if (r.mode == 3'd4) begin
            ex_bp <= {1'b1, 1'b1, rj, d0};
            repeat (2) begin
                @(negedge clk);
                check("o_ex_valid", 32'(ex_valid), 32'd0);
                check("o_br_taken", 32'(br_taken), 32'd0);
            end
            @(posedge clk);
            ex_bp <= '0;
        end
        if (r.mode == 3'd5) ex_allowin <= 1'b0;
        if (r.mode == 3'd6) begin
            if_valid  <= 1'b1;
            if_bundle <= {32'h0280_0000, pc + 32'd4};
        end
        wait_ex_valid();
        check_outputs(r, pc);
        if (r.mode == 3'd5) begin
            held = ex_bundle;
            check("o_id_allowin", 32'(id_allowin), 32'd0);
            @(negedge clk);
            check("held alu_src1", ex_bundle.alu_src1, held.alu_src1);
            check("held alu_src2", ex_bundle.alu_src2, held.alu_src2);
            check("held pc", ex_bundle.pc, held.pc);
            @(posedge clk);
            ex_allowin <= 1'b1;
            @(negedge clk);
            check("o_ex_valid", 32'(ex_valid), 32'd1);
            @(negedge clk);
            check("o_ex_valid", 32'(ex_valid), 32'd0);
        end
        @(posedge clk);
        ex_bp    <= '0;
        mem_bp   <= '0;
        wb_bp    <= '0;
        if_valid <= 1'b0;
        if (r.mode >= 3'd1 && r.mode <= 3'd3 && rj != 5'd0) shadow[rj] = d2;
        if (r.mode == 3'd6) begin
            @(negedge clk);
            check("o_ex_valid after taken branch", 32'(ex_valid), 32'd0);
        end
    endtask

    task automatic build_table();
        r3(5'h00, id_pkg::ALU_ADD, 5, 6, 7, 0);
        r3(5'h02, id_pkg::ALU_SUB, 5, 6, 7, 0);
        r3(5'h04, id_pkg::ALU_SLT, 5, 6, 7, 0);
        r3(5'h05, id_pkg::ALU_SLTU, 5, 6, 7, 0);
        r3(5'h08, id_pkg::ALU_NOR, 5, 6, 7, 0);
        r3(5'h09, id_pkg::ALU_AND, 5, 6, 7, 0);
        r3(5'h0a, id_pkg::ALU_OR, 5, 6, 7, 0);
        r3(5'h0b, id_pkg::ALU_XOR, 5, 6, 7, 0);
        r3(5'h0e, id_pkg::ALU_SLL, 5, 6, 7, 0);
        r3(5'h0f, id_pkg::ALU_SRL, 5, 6, 7, 0);
        r3(5'h10, id_pkg::ALU_SRA, 5, 6, 7, 0);
        // forwarding priority, r0, load-use stall, back-pressure
        r3(5'h00, id_pkg::ALU_ADD, 8, 9, 10, 1);
        r3(5'h00, id_pkg::ALU_ADD, 8, 9, 10, 2);
        r3(5'h00, id_pkg::ALU_ADD, 8, 9, 10, 3);
        r3(5'h00, id_pkg::ALU_ADD, 8, 0, 10, 1);
        r3(5'h00, id_pkg::ALU_ADD, 8, 9, 10, 4);
        r3(5'h02, id_pkg::ALU_SUB, 8, 6, 7, 5);
        add_row({6'h00, 4'h1, 2'h0, 5'h01, 5'd3, 5'd6, 5'd5}, id_pkg::ALU_SLL, id_pkg::MEM_NONE,
                id_pkg::BR_NONE, 1, 5, 3, 0, 1, 32'h023, 0, 0);
        add_row({6'h00, 4'h1, 2'h0, 5'h09, 5'd3, 5'd6, 5'd5}, id_pkg::ALU_SRL, id_pkg::MEM_NONE,
                id_pkg::BR_NONE, 1, 5, 3, 0, 1, 32'h123, 0, 0);
        add_row({6'h00, 4'h1, 2'h0, 5'h11, 5'd3, 5'd6, 5'd5}, id_pkg::ALU_SRA, id_pkg::MEM_NONE,
                id_pkg::BR_NONE, 1, 5, 3, 0, 1, 32'h223, 0, 0);
        add_row({6'h00, 4'ha, 12'hff0, 5'd6, 5'd5}, id_pkg::ALU_ADD, id_pkg::MEM_NONE,
                id_pkg::BR_NONE, 1, 5, 5'h10, 0, 1, 32'hffff_fff0, 0, 0);
        add_row({6'h00, 4'h8, 12'h801, 5'd6, 5'd5}, id_pkg::ALU_SLT, id_pkg::MEM_NONE,
                id_pkg::BR_NONE, 1, 5, 5'h01, 0, 1, 32'hffff_f801, 0, 0);
        add_row({6'h00, 4'h9, 12'h7ff, 5'd6, 5'd5}, id_pkg::ALU_SLTU, id_pkg::MEM_NONE,
                id_pkg::BR_NONE, 1, 5, 5'h1f, 0, 1, 32'h7ff, 0, 0);
        add_row({6'h00, 4'hd, 12'hf0f, 5'd6, 5'd5}, id_pkg::ALU_AND, id_pkg::MEM_NONE,
                id_pkg::BR_NONE, 1, 5, 5'h0f, 0, 1, 32'hf0f, 0, 0);
        add_row({6'h00, 4'he, 12'h8a5, 5'd6, 5'd5}, id_pkg::ALU_OR, id_pkg::MEM_NONE,
                id_pkg::BR_NONE, 1, 5, 5'h05, 0, 1, 32'h8a5, 0, 0);
        add_row({6'h00, 4'hf, 12'hfff, 5'd6, 5'd5}, id_pkg::ALU_XOR, id_pkg::MEM_NONE,
                id_pkg::BR_NONE, 1, 5, 5'h1f, 0, 1, 32'hfff, 0, 0);
        add_row({6'h05, 1'b0, 20'h12345, 5'd5}, id_pkg::ALU_LUI, id_pkg::MEM_NONE,
                id_pkg::BR_NONE, 1, 5, 5'h1a, 0, 1, 32'h1234_5000, 0, 0);
        add_row({6'h07, 1'b0, 20'hfedcb, 5'd5}, id_pkg::ALU_ADD, id_pkg::MEM_NONE,
                id_pkg::BR_NONE, 1, 5, 5'h0e, 1, 1, 32'hfedc_b000, 0, 0);
        add_row({6'h0a, 4'h0, 12'h004, 5'd6, 5'd5}, id_pkg::ALU_ADD, id_pkg::MEM_LD_B,
                id_pkg::BR_NONE, 1, 5, 5'h04, 0, 1, 32'h4, 0, 0);
        add_row({6'h0a, 4'h1, 12'hffe, 5'd6, 5'd5}, id_pkg::ALU_ADD, id_pkg::MEM_LD_H,
                id_pkg::BR_NONE, 1, 5, 5'h1e, 0, 1, 32'hffff_fffe, 0, 0);
        add_row({6'h0a, 4'h2, 12'h010, 5'd6, 5'd5}, id_pkg::ALU_ADD, id_pkg::MEM_LD_W,
                id_pkg::BR_NONE, 1, 5, 5'h10, 0, 1, 32'h10, 0, 0);
        add_row({6'h0a, 4'h8, 12'h003, 5'd6, 5'd5}, id_pkg::ALU_ADD, id_pkg::MEM_LD_BU,
                id_pkg::BR_NONE, 1, 5, 5'h03, 0, 1, 32'h3, 0, 0);
        add_row({6'h0a, 4'h9, 12'h002, 5'd6, 5'd5}, id_pkg::ALU_ADD, id_pkg::MEM_LD_HU,
                id_pkg::BR_NONE, 1, 5, 5'h02, 0, 1, 32'h2, 0, 0);
        add_row({6'h0a, 4'h4, 12'h001, 5'd6, 5'd7}, id_pkg::ALU_ADD, id_pkg::MEM_ST_B,
                id_pkg::BR_NONE, 0, 7, 7, 0, 1, 32'h1, 0, 0);
        add_row({6'h0a, 4'h5, 12'h802, 5'd6, 5'd7}, id_pkg::ALU_ADD, id_pkg::MEM_ST_H,
                id_pkg::BR_NONE, 0, 7, 7, 0, 1, 32'hffff_f802, 0, 0);
        add_row({6'h0a, 4'h6, 12'h008, 5'd6, 5'd7}, id_pkg::ALU_ADD, id_pkg::MEM_ST_W,
                id_pkg::BR_NONE, 0, 7, 7, 0, 1, 32'h8, 0, 0);
        add_row({6'h16, 16'h0010, 5'd6, 5'd7}, id_pkg::ALU_ADD, id_pkg::MEM_NONE,
                id_pkg::BR_BEQ, 0, 7, 7, 0, 0, 0, 32'h40, 0);
        add_row({6'h16, 16'h0010, 5'd6, 5'd6}, id_pkg::ALU_ADD, id_pkg::MEM_NONE,
                id_pkg::BR_BEQ, 0, 6, 6, 0, 0, 0, 32'h40, 0);
        add_row({6'h17, 16'hfff0, 5'd6, 5'd7}, id_pkg::ALU_ADD, id_pkg::MEM_NONE,
                id_pkg::BR_BNE, 0, 7, 7, 0, 0, 0, 32'hffff_ffc0, 0);
        add_row({6'h18, 16'h0020, 5'd6, 5'd7}, id_pkg::ALU_ADD, id_pkg::MEM_NONE,
                id_pkg::BR_BLT, 0, 7, 7, 0, 0, 0, 32'h80, 0);
        add_row({6'h19, 16'h0020, 5'd6, 5'd7}, id_pkg::ALU_ADD, id_pkg::MEM_NONE,
                id_pkg::BR_BGE, 0, 7, 7, 0, 0, 0, 32'h80, 0);
        add_row({6'h1a, 16'h8000, 5'd6, 5'd7}, id_pkg::ALU_ADD, id_pkg::MEM_NONE,
                id_pkg::BR_BLTU, 0, 7, 7, 0, 0, 0, 32'hfffe_0000, 0);
        add_row({6'h1b, 16'h0004, 5'd6, 5'd7}, id_pkg::ALU_ADD, id_pkg::MEM_NONE,
                id_pkg::BR_BGEU, 0, 7, 7, 0, 0, 0, 32'h10, 0);
        add_row({6'h13, 16'h0008, 5'd6, 5'd1}, id_pkg::ALU_ADD, id_pkg::MEM_NONE,
                id_pkg::BR_JIRL, 1, 1, 5'h08, 1, 1, 32'h4, 32'h20, 0);
        add_row({6'h14, 16'h0100, 10'h000}, id_pkg::ALU_ADD, id_pkg::MEM_NONE,
                id_pkg::BR_B, 0, 0, 5'h00, 0, 0, 0, 32'h400, 0);
        add_row({6'h15, 16'hfff0, 10'h3ff}, id_pkg::ALU_ADD, id_pkg::MEM_NONE,
                id_pkg::BR_BL, 1, 1, 5'h10, 1, 1, 32'h4, 32'hffff_ffc0, 6);
    endtask

    initial begin
        void'($urandom(32'h9468));
        resetn     = 1'b0;
        if_valid   = 1'b0;
        if_bundle  = '0;
        ex_allowin = 1'b1;
        ex_bp      = '0;
        mem_bp     = '0;
        wb_bp      = '0;
        shadow[0]  = 32'd0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        for (int a = 1; a < 32; a++) write_reg(a[4:0], $urandom);
        build_table();
        foreach (rows[i]) run_row(rows[i], 32'h1c00_0000 + 32'(i) * 32'h40);
        @(negedge clk);
        if (uut.u_props.fail_seen === 1'b1) begin
            $display("a bound assertion failed");
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* id_stage.f */
hw/id_pkg.sv
hw/inst_decoder.sv
hw/operand_fetch.sv
hw/issue_control.sv
hw/id_stage.sv
test/id_stage_properties.sv
test/id_stage_tb.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - hw/id_pkg.sv
  - hw/inst_decoder.sv
  - hw/operand_fetch.sv
  - hw/issue_control.sv
  - hw/id_stage.sv
  - target: test
    files:
      - test/id_stage_properties.sv
      - test/id_stage_tb.sv
